// File: tests/gpr_file_input.txt
# name op rd rs1 rs2 rs3 (decimal) wdata wdata_hi exp_rs1 exp_rs2 exp_rs3 exp_hi1 exp_hi2 (hex)
# op W = write, D = wide write, R = read check with rd_wen low (rd and data still driven)
reset_read R  0  0  5 31 00000000 00000000 00000000 00000000 00000000 00000000 00000000
w_r2       W  2  0  0  0 11112222 00000000 00000000 00000000 00000000 00000000 00000000
w_r3       W  3  0  0  0 33334444 00000000 00000000 00000000 00000000 00000000 00000000
w_r10      W 10  0  0  0 a0a0a0a0 00000000 00000000 00000000 00000000 00000000 00000000
w_r17      W 17  0  0  0 17171717 00000000 00000000 00000000 00000000 00000000 00000000
w_r30      W 30  0  0  0 30303030 00000000 00000000 00000000 00000000 00000000 00000000
w_r31      W 31  0  0  0 31313131 00000000 00000000 00000000 00000000 00000000 00000000
rd_mix_a   R  0  2  3 10 00000000 00000000 11112222 33334444 a0a0a0a0 33334444 33334444
rd_mix_b   R  0 17 30 31 00000000 00000000 17171717 30303030 31313131 17171717 31313131
rd_mix_c   R  0 31 10  2 00000000 00000000 31313131 a0a0a0a0 11112222 31313131 00000000
w_r0       W  0  0  0  0 deadbeef 00000000 00000000 00000000 00000000 00000000 00000000
w_r1       W  1  0  0  0 01010101 00000000 00000000 00000000 00000000 00000000 00000000
rd_r0_r1   R  0  0  1  0 00000000 00000000 00000000 01010101 00000000 01010101 01010101
wd_r6      D  6  0  0  0 66666666 77777777 00000000 00000000 00000000 00000000 00000000
rd_wide6   R  0  6  6  7 00000000 00000000 66666666 66666666 77777777 77777777 77777777
wd_r0      D  0  0  0  0 0badf00d 12345678 00000000 00000000 00000000 00000000 00000000
rd_wide0   R  0  0  0  1 00000000 00000000 00000000 00000000 12345678 12345678 12345678
wd_r20     D 20  0  0  0 aaaa5555 5555aaaa 00000000 00000000 00000000 00000000 00000000
rd_wide20  R  0 20 21 20 00000000 00000000 aaaa5555 5555aaaa aaaa5555 5555aaaa 5555aaaa
wd_r30     D 30  0  0  0 fedcba98 76543210 00000000 00000000 00000000 00000000 00000000
rd_wide30  R  0 30 31 17 00000000 00000000 fedcba98 76543210 17171717 76543210 76543210
nowr_a     R  2  2  3 10 ffffffff eeeeeeee 11112222 33334444 a0a0a0a0 33334444 33334444
nowr_b     R 10  2 10  6 cccccccc dddddddd 11112222 a0a0a0a0 66666666 33334444 00000000
nowr_final R  6  1 10 30 bbbbbbbb 99999999 12345678 a0a0a0a0 fedcba98 12345678 00000000
w_r3b      W  3  0  0  0 c0ffee03 00000000 00000000 00000000 00000000 00000000 00000000
rd_r3b     R  0  3  2  3 00000000 00000000 c0ffee03 11112222 c0ffee03 c0ffee03 c0ffee03

// File: tests/tb_gpr_file.sv
////////////////////////////////////////
// GPR file testbench
// Applies writes, wide writes and read
// checks taken from the stimulus file
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_gpr_file;
    import gpr_pkg::*;

    typedef struct packed {
        reg_addr_t rd_addr;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rs3;
        reg_data_t wdata;
        reg_data_t wdata_hi;
        reg_data_t exp_rs1;
        reg_data_t exp_rs2;
        reg_data_t exp_rs3;
        reg_data_t exp_hi1;
        reg_data_t exp_hi2;
    } vector_t;

    logic      g_clk;
    logic      rst_n;
    reg_addr_t rs1_addr, rs2_addr, rs3_addr;
    reg_data_t rs1_data, rs2_data, rs3_data;
    reg_data_t rs1_rdhi, rs2_rdhi;
    logic      rd_wen, rd_wide;
    reg_addr_t rd_addr;
    reg_data_t rd_wdata, rd_wdata_hi;

    vector_t vec_q [$];
    string   name_q [$];
    string   op_q [$];

    int vec_count;
    int load_errors;
    int cycle_count;
    int cycle_limit;
    int check_count;
    int error_count;
    int reads_passed;
    int reads_failed;
    int writes_done;
    bit test_failed;

    gpr_file gpr_file_i (
        .g_clk       (g_clk),
        .rst_n       (rst_n),
        .rs1_addr    (rs1_addr),
        .rs1_data    (rs1_data),
        .rs1_rdhi    (rs1_rdhi),
        .rs2_addr    (rs2_addr),
        .rs2_data    (rs2_data),
        .rs2_rdhi    (rs2_rdhi),
        .rs3_addr    (rs3_addr),
        .rs3_data    (rs3_data),
        .rd_wen      (rd_wen),
        .rd_wide     (rd_wide),
        .rd_addr     (rd_addr),
        .rd_wdata    (rd_wdata),
        .rd_wdata_hi (rd_wdata_hi)
    );

    always #50 g_clk = ~g_clk;                   // 100 ns period

    // Watchdog on total run length
    always @(posedge g_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run reached %0d cycles before the tests finished", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic load_vectors;
        int        fd;
        int        got;
        string     line;
        string     name;
        string     op;
        int        rd_a, a1, a2, a3;
        reg_data_t wd, wh, e1, e2, e3, h1, h2;
        vector_t   v;
        fd = $fopen("tests/gpr_file_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/gpr_file_input.txt");
            load_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got  = $fgets(line, fd);
                if (got > 1 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%s %s %d %d %d %d %h %h %h %h %h %h %h",
                                  name, op, rd_a, a1, a2, a3, wd, wh, e1, e2, e3, h1, h2);
                    if (got == 13) begin
                        v.rd_addr  = reg_addr_t'(rd_a);
                        v.rs1      = reg_addr_t'(a1);
                        v.rs2      = reg_addr_t'(a2);
                        v.rs3      = reg_addr_t'(a3);
                        v.wdata    = wd;
                        v.wdata_hi = wh;
                        v.exp_rs1  = e1;
                        v.exp_rs2  = e2;
                        v.exp_rs3  = e3;
                        v.exp_hi1  = h1;
                        v.exp_hi2  = h2;
                        vec_q.push_back(v);
                        name_q.push_back(name);
                        op_q.push_back(op);
                    end else begin
                        $display("Malformed stimulus line: %s", line);
                        load_errors++;
                    end
                end
            end
            $fclose(fd);
        end
        vec_count = vec_q.size();
    endtask

    // Reads also carry rd_addr and data, with rd_wen held low
    task automatic drive_inputs(input int i);
        rd_wen      = (op_q[i] != "R");
        rd_wide     = (op_q[i] == "D");
        rd_addr     = vec_q[i].rd_addr;
        rd_wdata    = vec_q[i].wdata;
        rd_wdata_hi = vec_q[i].wdata_hi;
        rs1_addr    = vec_q[i].rs1;
        rs2_addr    = vec_q[i].rs2;
        rs3_addr    = vec_q[i].rs3;
    endtask

    task automatic compare_word(input string test, input string port,
                                input reg_data_t expected, input reg_data_t actual);
        check_count++;
        if (actual !== expected) begin
            $display("FAILED %s %s expected %h actual %h", test, port, expected, actual);
            error_count++;
            test_failed = 1'b1;
        end
    endtask

    task automatic check_read(input int i);
        test_failed = 1'b0;
        compare_word(name_q[i], "rs1_data", vec_q[i].exp_rs1, rs1_data);
        compare_word(name_q[i], "rs2_data", vec_q[i].exp_rs2, rs2_data);
        compare_word(name_q[i], "rs3_data", vec_q[i].exp_rs3, rs3_data);
        compare_word(name_q[i], "rs1_rdhi", vec_q[i].exp_hi1, rs1_rdhi);
        compare_word(name_q[i], "rs2_rdhi", vec_q[i].exp_hi2, rs2_rdhi);
        if (test_failed) begin
            reads_failed++;
        end else begin
            reads_passed++;
            $display("PASSED %s", name_q[i]);
        end
    endtask

    initial begin
        g_clk       = 1'b0;
        rst_n       = 1'b0;
        rd_wen      = 1'b0;
        rd_wide     = 1'b0;
        rd_addr     = '0;
        rd_wdata    = '0;
        rd_wdata_hi = '0;
        rs1_addr    = '0;
        rs2_addr    = '0;
        rs3_addr    = '0;
        cycle_count = 0;
        cycle_limit = 20;
        load_vectors();
        cycle_limit = 4 * vec_count + 20;            // Reset plus one cycle per line, with margin
        if (load_errors != 0 || vec_count == 0) begin
            $display("Stimulus file missing or malformed, no tests run");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            repeat (3) @(posedge g_clk);
            #10 rst_n = 1'b1;
            for (int i = 0; i < vec_count; i++) begin
                @(posedge g_clk);
                #10 drive_inputs(i);
                if (op_q[i] == "R") begin
                    @(negedge g_clk);                // Mid cycle, reads settled
                    check_read(i);
                end else begin
                    writes_done++;
                    $display("DONE   %s %s to x%0d", name_q[i],
                             (op_q[i] == "D") ? "wide write" : "write", vec_q[i].rd_addr);
                end
            end
            @(posedge g_clk);
            #10 rd_wen = 1'b0;
            @(posedge g_clk);
            $display("Summary: %0d lines, %0d writes, %0d/%0d reads passed, %0d/%0d checks wrong",
                     vec_count, writes_done, reads_passed, reads_passed + reads_failed,
                     error_count, check_count);
            if (error_count == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog/gpr_bank.sv
////////////////////////////////////////
// GPR bank
// Sixteen registers, one write port and
// three combinational read ports
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "gpr_defines.svh"

module gpr_bank #(
    parameter bit hardwire_zero = 1'b0       // Entry 0 is constant zero
) (
    input  wire       g_clk,
    input  wire       rst_n,
    gpr_bank_if.bank  port
);
    import gpr_pkg::*;

    reg_data_t regs [`GPR_BANK_DEPTH];       // Bank storage
    logic      wr_blocked;                   // Write aimed at frozen entry 0

    assign wr_blocked = hardwire_zero && (port.windex == '0);

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `GPR_BANK_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (port.wen && !wr_blocked) begin
            regs[port.windex] <= port.wdata;
        end
    end

    // Reads see the stored value, a write lands next cycle
    always_comb begin
        for (int i = 0; i < `GPR_NUM_READ; i++) begin
            port.rdata[i] = regs[port.rindex[i]];
        end
    end

    generate
        if (hardwire_zero) begin : g_zero_check
            // Entry 0 never leaves zero, whatever the write traffic
            a_entry0_zero : assert property (
                @(posedge g_clk) disable iff (!rst_n)
                (port.wen && port.windex == '0) |=> (regs[0] == '0)
            ) else $error("entry 0 of a zero bank was written");
        end
    endgenerate

endmodule

`default_nettype wire

// File: verilog/gpr_bank_if.sv
////////////////////////////////////////
// GPR bank interface
// Write request, read indices and read data
// of one register bank
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "gpr_defines.svh"

interface gpr_bank_if;
    import gpr_pkg::*;

    logic      wen;                          // Write strobe, taken at clock edge
    bank_idx_t windex;                       // Entry to write
    reg_data_t wdata;                        // Word to write
    bank_idx_t rindex [`GPR_NUM_READ];       // Entry per read port
    reg_data_t rdata  [`GPR_NUM_READ];       // Word per read port

    modport decode (output wen, output windex, output wdata, output rindex);

    modport bank (input wen, input windex, input wdata, input rindex, output rdata);

    modport select (input rdata);

endinterface

`default_nettype wire

// File: verilog/gpr_defines.svh
////////////////////////////////////////
// GPR constants
// Sizes of the register file and its banks
////////////////////////////////////////
`ifndef GPR_DEFINES_SVH
`define GPR_DEFINES_SVH

`define GPR_NUM_REGS   32   // Architectural registers
`define GPR_NUM_BANKS  2    // Even and odd bank
`define GPR_BANK_DEPTH 16   // Entries per bank
`define GPR_NUM_READ   3    // Source read ports
`define GPR_XLEN       32   // Register width

`endif

// File: verilog/gpr_file.sv
////////////////////////////////////////
// GPR file top level
// 32 x 32-bit registers in two banks with
// three read ports and a paired write
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "gpr_defines.svh"

module gpr_file (
    input  wire                     g_clk,
    input  wire                     rst_n,

    input  wire gpr_pkg::reg_addr_t rs1_addr,     // Source 1 register
    output gpr_pkg::reg_data_t      rs1_data,
    output gpr_pkg::reg_data_t      rs1_rdhi,     // Source 1 high word

    input  wire gpr_pkg::reg_addr_t rs2_addr,     // Source 2 register
    output gpr_pkg::reg_data_t      rs2_data,
    output gpr_pkg::reg_data_t      rs2_rdhi,     // Source 2 high word

    input  wire gpr_pkg::reg_addr_t rs3_addr,     // Source 3 register
    output gpr_pkg::reg_data_t      rs3_data,

    input  wire                     rd_wen,       // Destination write enable
    input  wire                     rd_wide,      // Paired write, rd_addr even
    input  wire gpr_pkg::reg_addr_t rd_addr,
    input  wire gpr_pkg::reg_data_t rd_wdata,     // Bits 31:0
    input  wire gpr_pkg::reg_data_t rd_wdata_hi   // Bits 63:32 on a wide write
);

    gpr_bank_if bank_if [`GPR_NUM_BANKS] ();      // Index 0 even, 1 odd

    gpr_port_decode u_decode (
        .rd_wen      (rd_wen),
        .rd_wide     (rd_wide),
        .rd_addr     (rd_addr),
        .rd_wdata    (rd_wdata),
        .rd_wdata_hi (rd_wdata_hi),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs3_addr    (rs3_addr),
        .even_bank   (bank_if[0]),
        .odd_bank    (bank_if[1])
    );

    // Only the even bank holds register 0
    generate
        for (genvar b = 0; b < `GPR_NUM_BANKS; b++) begin : g_bank
            gpr_bank #(
                .hardwire_zero (b == 0)
            ) u_bank (
                .g_clk (g_clk),
                .rst_n (rst_n),
                .port  (bank_if[b])
            );
        end
    endgenerate

    gpr_read_select u_select (
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs3_addr  (rs3_addr),
        .even_bank (bank_if[0]),
        .odd_bank  (bank_if[1]),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .rs3_data  (rs3_data),
        .rs1_rdhi  (rs1_rdhi),
        .rs2_rdhi  (rs2_rdhi)
    );

    // A plain write to a nonzero register reads back on rs1 one cycle later
    a_write_readback : assert property (
        @(posedge g_clk) disable iff (!rst_n)
        (rd_wen && !rd_wide && rd_addr != '0) |=>
            (rs1_addr != $past(rd_addr)) || (rs1_data == $past(rd_wdata))
    ) else $error("register %0d did not read back its write", $past(rd_addr));

endmodule

`default_nettype wire

// File: verilog/gpr_pkg.sv
////////////////////////////////////////
// GPR package
// Vector types shared by the register file
////////////////////////////////////////
`default_nettype none

`include "gpr_defines.svh"

package gpr_pkg;

    // Register number, bit 0 picks the bank
    typedef logic [$clog2(`GPR_NUM_REGS)-1:0]   reg_addr_t;

    typedef logic [`GPR_XLEN-1:0]               reg_data_t;   // One register word

    // Upper address bits, entry within a bank
    typedef logic [$clog2(`GPR_BANK_DEPTH)-1:0] bank_idx_t;

endpackage

`default_nettype wire

// File: verilog/gpr_port_decode.sv
////////////////////////////////////////
// GPR port decoder
// Splits destination and source addresses
// into even and odd bank requests
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "gpr_defines.svh"

module gpr_port_decode (
    input  wire                 rd_wen,        // Destination write enable
    input  wire                 rd_wide,       // Paired 64-bit write
    input  wire gpr_pkg::reg_addr_t rd_addr,   // Destination register
    input  wire gpr_pkg::reg_data_t rd_wdata,  // Low word, or the only word
    input  wire gpr_pkg::reg_data_t rd_wdata_hi, // High word of a wide write
    input  wire gpr_pkg::reg_addr_t rs1_addr,
    input  wire gpr_pkg::reg_addr_t rs2_addr,
    input  wire gpr_pkg::reg_addr_t rs3_addr,
    gpr_bank_if.decode              even_bank,
    gpr_bank_if.decode              odd_bank
);
    import gpr_pkg::*;

    reg_addr_t rs_addr [`GPR_NUM_READ];      // Source addresses as an array
    bank_idx_t rd_index;                     // Pair number of the destination
    logic      rd_odd;

    assign rs_addr[0] = rs1_addr;
    assign rs_addr[1] = rs2_addr;
    assign rs_addr[2] = rs3_addr;

    assign rd_odd   = rd_addr[0];
    assign rd_index = bank_idx_t'(rd_addr >> 1);

    // Write side
    assign even_bank.wen    = rd_wen && !rd_odd;
    assign even_bank.windex = rd_index;
    assign even_bank.wdata  = rd_wdata;

    assign odd_bank.wen     = rd_wen && (rd_odd || rd_wide);
    assign odd_bank.windex  = rd_index;
    assign odd_bank.wdata   = rd_wide ? rd_wdata_hi : rd_wdata;   // High half on wide

    // Both banks look up the same pair for a source
    always_comb begin
        for (int i = 0; i < `GPR_NUM_READ; i++) begin
            even_bank.rindex[i] = bank_idx_t'(rs_addr[i] >> 1);
            odd_bank.rindex[i]  = bank_idx_t'(rs_addr[i] >> 1);
        end
    end

    // A wide write must name the even register of its pair
    always_comb begin
        if (rd_wen && rd_wide) begin
            assert #0 (!rd_odd)
                else $error("wide write to odd register %0d", rd_addr);
        end
    end

endmodule

`default_nettype wire

// File: verilog/gpr_read_select.sv
////////////////////////////////////////
// GPR read selector
// Picks the even or odd word per source
// port and forms the wide high words
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "gpr_defines.svh"

module gpr_read_select (
    input  wire gpr_pkg::reg_addr_t rs1_addr,
    input  wire gpr_pkg::reg_addr_t rs2_addr,
    input  wire gpr_pkg::reg_addr_t rs3_addr,
    gpr_bank_if.select              even_bank,
    gpr_bank_if.select              odd_bank,
    output gpr_pkg::reg_data_t      rs1_data,
    output gpr_pkg::reg_data_t      rs2_data,
    output gpr_pkg::reg_data_t      rs3_data,
    output gpr_pkg::reg_data_t      rs1_rdhi,   // Odd word of the rs1 pair
    output gpr_pkg::reg_data_t      rs2_rdhi    // Odd word of the rs2 pair
);
    import gpr_pkg::*;

    reg_addr_t rs_addr [`GPR_NUM_READ];
    reg_data_t rs_data [`GPR_NUM_READ];

    assign rs_addr[0] = rs1_addr;
    assign rs_addr[1] = rs2_addr;
    assign rs_addr[2] = rs3_addr;

    // Bit 0 of the register number chooses the bank
    always_comb begin
        for (int i = 0; i < `GPR_NUM_READ; i++) begin
            rs_data[i] = rs_addr[i][0] ? odd_bank.rdata[i] : even_bank.rdata[i];
        end
    end

    assign rs1_data = rs_data[0];
    assign rs2_data = rs_data[1];
    assign rs3_data = rs_data[2];

    // Wide reads return the odd register regardless of bit 0
    assign rs1_rdhi = odd_bank.rdata[0];
    assign rs2_rdhi = odd_bank.rdata[1];

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verilog
verilog/gpr_pkg.sv
verilog/gpr_bank_if.sv
verilog/gpr_port_decode.sv
verilog/gpr_bank.sv
verilog/gpr_read_select.sv
verilog/gpr_file.sv
tests/tb_gpr_file.sv
